// File: hdl/ws2801_cfg.svh
`ifndef WS2801_CFG_SVH
`define WS2801_CFG_SVH

// ----------------------------------------
// strip geometry
// ----------------------------------------

// number of driver cells along the chain
`define LED_NUM_PIXELS 4

// buffer depth, equal to the host's starting credit count
`define LED_FIFO_DEPTH 8

// ----------------------------------------
// serial timing, in CKI cycles
// ----------------------------------------

`define LED_SCK_HALF 4     // half period of sck, at least 2

// a cell latches after this many cycles with no sck rising edge
`define LED_LATCH_IDLE 40

// serializer idle time after a last word, must exceed LED_LATCH_IDLE + 2
`define LED_LATCH_GAP 64

`endif

// File: hdl/ledPkg.sv
package ledPkg;

    // ----------------------------------------
    // color and pixel words
    // ----------------------------------------

    // 24 bit color, red[7] is the msb and blue[0] the lsb on the wire
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // word pushed by the host
    typedef struct packed {
        rgb_t color;    // payload shifted out msb first
        logic last;     // marks the final pixel of a frame
    } pixelWord_t;

    // ----------------------------------------
    // serial line
    // ----------------------------------------

    // two-wire stream, serializer to cell 0 and cell to cell
    typedef struct packed {
        logic sck;      // serial clock, data sampled on its rise
        logic sda;      // serial data, only changes while sck is low
    } serialLine_t;

endpackage

// File: hdl/pixelFifo.sv
`timescale 1ns/1ps

module pixelFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     CKI,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t head,
    output logic     notEmpty,
    output logic     creditReturn
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ----------------------------------------
    // storage and pointers
    // ----------------------------------------

    payload_t         mem [DEPTH];     // circular storage
    logic [PTR_W-1:0] wrPtr;           // next slot to write
    logic [PTR_W-1:0] rdPtr;           // slot presented on head
    logic [CNT_W-1:0] count;           // words held from 0 to DEPTH

    // wrap at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge CKI) begin
        if (push) begin
            mem[wrPtr] <= din;          // payload into the free slot
        end
    end

    always_ff @(posedge CKI) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // occupancy only moves when exactly one side is active
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------

    assign head         = mem[rdPtr];   // first-word fall-through
    assign notEmpty     = (count != '0);
    assign creditReturn = pop;          // one credit back per word taken

    // host spent a credit it did not have
    aNoPushFull : assert property (@(posedge CKI) disable iff (rst)
        push |-> (count != CNT_W'(DEPTH)))
        else $error("pixelFifo: push while full");

    // consumer must look at notEmpty before taking a word
    aNoPopEmpty : assert property (@(posedge CKI) disable iff (rst)
        pop |-> notEmpty)
        else $error("pixelFifo: pop while empty");

endmodule

// File: hdl/ws2801Serializer.sv
`timescale 1ns/1ps

`include "ws2801_cfg.svh"

module ws2801Serializer (
    input  logic                CKI,
    input  logic                rst,
    input  ledPkg::pixelWord_t  head,
    input  logic                notEmpty,
    output logic                pop,
    output ledPkg::serialLine_t lineOut
);

    localparam int BIT_LEN = 2 * `LED_SCK_HALF;              // cycles per bit
    localparam int PH_W    = $clog2(BIT_LEN);
    localparam int GAP_W   = $clog2(`LED_LATCH_GAP + 1);

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for a word
        ST_SHIFT,    // clocking 24 bits out
        ST_GAP       // line held low so the strip latches
    } serState_t;

    // ----------------------------------------
    // state
    // ----------------------------------------

    serState_t         state;
    logic [PH_W-1:0]   phase;      // position inside the current bit
    logic [4:0]        bitCnt;     // 0..23, bit being sent
    logic [GAP_W-1:0]  gapCnt;     // cycles spent in the latch gap
    logic              lastQ;      // current word closes a frame
    logic [23:0]       shiftBits;  // msb is on sda

    logic bitEnd;
    logic wordEnd;

    assign bitEnd  = (phase == PH_W'(BIT_LEN - 1));
    assign wordEnd = bitEnd && (bitCnt == 5'd23);

    // pop straight out of idle, the buffer shows its head word already
    assign pop = (state == ST_IDLE) && notEmpty;

    always_ff @(posedge CKI) begin
        if (rst) begin
            state  <= ST_IDLE;
            phase  <= '0;
            bitCnt <= '0;
            gapCnt <= '0;
            lastQ  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (notEmpty) begin
                        state  <= ST_SHIFT;
                        phase  <= '0;
                        bitCnt <= '0;
                        lastQ  <= head.last;   // remembered for the end of word
                    end
                end
                ST_SHIFT: begin
                    if (bitEnd) begin
                        phase <= '0;
                        if (wordEnd) begin
                            bitCnt <= '0;
                            gapCnt <= '0;
                            // frame done, give the cells time to latch
                            state  <= lastQ ? ST_GAP : ST_IDLE;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                ST_GAP: begin
                    if (gapCnt == GAP_W'(`LED_LATCH_GAP - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // data path, loads on pop and moves one place per bit
    always_ff @(posedge CKI) begin
        if (pop) begin
            shiftBits <= head.color;                     // red[7] lands on top
        end else if ((state == ST_SHIFT) && bitEnd) begin
            shiftBits <= {shiftBits[22:0], 1'b0};
        end
    end

    // ----------------------------------------
    // line drive
    // ----------------------------------------

    // sck low for the first half of the bit, high for the second
    assign lineOut.sck = (state == ST_SHIFT) && (phase >= PH_W'(`LED_SCK_HALF));
    assign lineOut.sda = (state == ST_SHIFT) && shiftBits[23];   // low when idle

    // data must be settled for the whole high phase
    aSdaStable : assert property (@(posedge CKI) disable iff (rst)
        (lineOut.sck && $past(lineOut.sck)) |-> $stable(lineOut.sda))
        else $error("ws2801Serializer: sda moved while sck high");

endmodule

// File: hdl/ws2801Pixel.sv
`timescale 1ns/1ps

`include "ws2801_cfg.svh"

module ws2801Pixel (
    input  logic                CKI,
    input  logic                rst,
    input  ledPkg::serialLine_t lineIn,
    output ledPkg::serialLine_t lineOut,
    output ledPkg::rgb_t        rgb
);

    import ledPkg::*;

    localparam int IDLE_W = $clog2(`LED_LATCH_IDLE + 1);

    // ----------------------------------------
    // cell registers
    // ----------------------------------------

    logic              sckQ;       // sck one cycle ago
    logic [23:0]       shiftBits;  // incoming color msb first
    logic [4:0]        bitCnt;     // bits taken in since the last latch
    logic              relay;      // own word full so the line passes on
    logic [IDLE_W-1:0] idleCnt;    // cycles since the last sck rise
    rgb_t              colorQ;     // displayed color

    logic sckRise;
    logic latchNow;

    assign sckRise  = lineIn.sck && !sckQ;
    // last idle cycle before the limit with nothing arriving
    assign latchNow = !sckRise && (idleCnt == IDLE_W'(`LED_LATCH_IDLE - 1));

    always_ff @(posedge CKI) begin
        if (sckRise && (bitCnt < 5'd24)) begin
            shiftBits <= {shiftBits[22:0], lineIn.sda};   // sda stable while sck high
        end
    end

    always_ff @(posedge CKI) begin
        if (rst) begin
            sckQ    <= 1'b0;
            bitCnt  <= '0;
            relay   <= 1'b0;
            idleCnt <= IDLE_W'(`LED_LATCH_IDLE);  // start saturated so no latch before data
            colorQ  <= '0;
        end else begin
            sckQ <= lineIn.sck;

            if (sckRise) begin
                idleCnt <= '0;                     // any edge restarts the timeout
                if (bitCnt < 5'd24) begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end else if (latchNow) begin
                idleCnt <= IDLE_W'(`LED_LATCH_IDLE);   // saturate so the cell latches once
                colorQ  <= rgb_t'(shiftBits);
                bitCnt  <= '0;
                relay   <= 1'b0;
            end else if (idleCnt != IDLE_W'(`LED_LATCH_IDLE)) begin
                idleCnt <= idleCnt + 1'b1;
            end

            // open the relay once sck has dropped after the 24th bit
            // so the next cell never sees the tail of our last pulse
            if (!relay && (bitCnt == 5'd24) && !lineIn.sck && !latchNow) begin
                relay <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign lineOut = relay ? lineIn : '0;   // held low until our word is in
    assign rgb     = colorQ;

    // the rise after bit 24 has to find the relay already open
    aRelayBeforeEdge : assert property (@(posedge CKI) disable iff (rst)
        (sckRise && (bitCnt == 5'd24)) |-> relay)
        else $error("ws2801Pixel: sck rise after bit 24 with relay still closed");

endmodule

// File: hdl/ledStrip.sv
`timescale 1ns/1ps

`include "ws2801_cfg.svh"

module ledStrip (
    input  logic                CKI,
    input  logic                rst,
    input  ledPkg::pixelWord_t  pixIn,
    input  logic                pixValid,
    output logic                creditReturn,
    output ledPkg::serialLine_t chainOut,
    output ledPkg::rgb_t        rgbOut [`LED_NUM_PIXELS]
);

    import ledPkg::*;

    // ----------------------------------------
    // interconnect
    // ----------------------------------------

    pixelWord_t  headWord;                      // buffer head into the serializer
    logic        fifoNotEmpty;
    logic        fifoPop;
    serialLine_t link [`LED_NUM_PIXELS + 1];    // link[0] from serializer

    // sck needs a distinct low and high phase of at least two cycles each
    if (`LED_SCK_HALF < 2) begin : gBadHalf
        $error("ledStrip: LED_SCK_HALF must be at least 2");
    end

    // host words land here, credits go back on each pop
    pixelFifo #(
        .payload_t (pixelWord_t),
        .DEPTH     (`LED_FIFO_DEPTH)
    ) uFifo (
        .CKI          (CKI),
        .rst          (rst),
        .push         (pixValid),
        .din          (pixIn),
        .pop          (fifoPop),
        .head         (headWord),
        .notEmpty     (fifoNotEmpty),
        .creditReturn (creditReturn)
    );

    ws2801Serializer uSer (
        .CKI      (CKI),
        .rst      (rst),
        .head     (headWord),
        .notEmpty (fifoNotEmpty),
        .pop      (fifoPop),
        .lineOut  (link[0])
    );

    // ----------------------------------------
    // cell chain, position 0 nearest the serializer
    // ----------------------------------------

    for (genvar i = 0; i < `LED_NUM_PIXELS; i++) begin : gCell
        ws2801Pixel uCell (
            .CKI     (CKI),
            .rst     (rst),
            .lineIn  (link[i]),
            .lineOut (link[i + 1]),
            .rgb     (rgbOut[i])
        );
    end

    assign chainOut = link[`LED_NUM_PIXELS];   // whatever the last cell passes on

endmodule

// File: sim/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    // ----------------------------------------
    // random colors
    // ----------------------------------------

    // 32 bit xorshift step, 13/17/5 taps
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rgb_t randomColor();
        rngState = xorshift32(rngState);
        return rgb_t'(rngState[23:0]);   // low 24 bits as red, green, blue
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic checkRgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic checkLine(input string name, input serialLine_t got,
                             input serialLine_t exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got sck=%b sda=%b expected sck=%b sda=%b",
                     $time, name, got.sck, got.sda, exp.sck, exp.sda);
            failRun();
        end
    endtask

    // ----------------------------------------
    // host side push
    // ----------------------------------------

    // one word per call, spends a credit, waits while none is left
    task automatic pushPixel(input pixelWord_t w);
        while (credits == 0) begin
            @(posedge CKI);
            #DRIVE_DELAY;
            stallCycles++;                // credits come back at negedge
        end
        pixIn    = w;
        pixValid = 1'b1;
        credits  = credits - 1;
        @(posedge CKI);                   // word accepted on this edge
        #DRIVE_DELAY;
        pixValid = 1'b0;
    endtask

`endif

// File: sim/tbLedStrip.sv
`timescale 1ns/1ps

`include "ws2801_cfg.svh"

module tbLedStrip;

    import ledPkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;                        // after each rising edge
    localparam int WORD_CYCLES = 48 * `LED_SCK_HALF;        // 24 bits of 2 half periods
    localparam int LONG_LEN    = 2 * `LED_FIFO_DEPTH + 3;   // frame longer than the buffer
    // words pushed by all tests together
    localparam int TOTAL_WORDS = `LED_FIFO_DEPTH + `LED_NUM_PIXELS + LONG_LEN
                               + 2 * `LED_NUM_PIXELS + 2 + `LED_NUM_PIXELS + 1;
    localparam int LATCH_WAITS     = 6;                     // one per drain wait
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * WORD_CYCLES
                                   + LATCH_WAITS * `LED_LATCH_GAP + 2000;

    logic        CKI;
    logic        rst;
    pixelWord_t  pixIn;
    logic        pixValid;
    logic        creditReturn;
    serialLine_t chainOut;
    rgb_t        rgbOut [`LED_NUM_PIXELS];

    int          credits;                    // host credit count
    int          returnCount;                // creditReturn pulses seen
    int          stallCycles;                // cycles pushPixel waited for a credit
    logic [31:0] rngState;
    rgb_t        sent [LONG_LEN];            // colors of the latest frame
    rgb_t        shown [`LED_NUM_PIXELS];    // expected strip contents
    logic        sckPrev = 1'b0;
    logic [23:0] capWord;                    // bits rebuilt from chainOut
    int          capBits;

    task automatic failRun();
        $display("sim failed");
        $fatal(1);
    endtask

    `include "tbChecks.svh"

    ledStrip UUT (
        .CKI          (CKI),
        .rst          (rst),
        .pixIn        (pixIn),
        .pixValid     (pixValid),
        .creditReturn (creditReturn),
        .chainOut     (chainOut),
        .rgbOut       (rgbOut)
    );

    initial begin
        CKI = 1'b0;
        forever #(CLK_PERIOD / 2) CKI = ~CKI;
    end

    // ----------------------------------------
    // monitors sampled mid cycle
    // ----------------------------------------

    always @(negedge CKI) begin
        if (!rst && creditReturn) begin
            credits     = credits + 1;   // word popped so one credit comes back
            returnCount = returnCount + 1;
        end
    end

    // sda is taken at each sck rise on the far end of the chain
    always @(negedge CKI) begin
        if (!rst && chainOut.sck && !sckPrev) begin
            capWord = {capWord[22:0], chainOut.sda};
            capBits = capBits + 1;
        end
        sckPrev = chainOut.sck;
    end

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        failRun();
    end

    // ----------------------------------------
    // frame helpers
    // ----------------------------------------

    task automatic pushFrame(input int len);
        pixelWord_t w;
        for (int i = 0; i < len; i++) begin
            w.color = randomColor();
            w.last  = (i == len - 1);     // flag closes the frame
            sent[i] = w.color;
            pushPixel(w);
        end
        for (int k = 0; k < `LED_NUM_PIXELS; k++) begin
            if (k < len) shown[k] = sent[k];   // cell k takes word k and the rest keep theirs
        end
    endtask

    // last word popped then its shift time plus the latch gap
    task automatic waitDrain();
        while (credits != `LED_FIFO_DEPTH) begin
            @(posedge CKI);
            #DRIVE_DELAY;
        end
        repeat (WORD_CYCLES + `LED_LATCH_GAP + 4) @(posedge CKI);
        #DRIVE_DELAY;
    endtask

    task automatic checkStrip();
        for (int k = 0; k < `LED_NUM_PIXELS; k++) begin
            checkRgb($sformatf("rgbOut[%0d]", k), rgbOut[k], shown[k]);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic testReset();
        checkLine("chainOut", chainOut, serialLine_t'(2'b00));
        checkStrip();                                  // shown starts all zero
        repeat (3) @(posedge CKI);
        #DRIVE_DELAY;
        if (returnCount != 0 || credits != `LED_FIFO_DEPTH) begin
            $display("credit returned or credits not at buffer depth before any push");
            failRun();
        end
        pushFrame(`LED_FIFO_DEPTH);                    // full depth in one burst
        // only the first word leaves the buffer while the burst goes in
        if (returnCount != 1) begin
            $display("expected one credit back during the burst but saw %0d", returnCount);
            failRun();
        end
        waitDrain();
        checkStrip();
    endtask

    task automatic testLongFrame();
        stallCycles = 0;
        pushFrame(LONG_LEN);
        if (stallCycles == 0) begin
            $display("long frame never ran out of credits");
            failRun();
        end
        waitDrain();
        checkStrip();
        if (credits != `LED_FIFO_DEPTH) begin
            $display("credit count did not settle at buffer depth after draining");
            failRun();
        end
    endtask

    task automatic testOverlong();
        capBits = 0;
        capWord = '0;
        pushFrame(`LED_NUM_PIXELS + 1);
        waitDrain();
        checkStrip();
        if (capBits != 24) begin
            $display("chainOut carried %0d bits instead of 24", capBits);
            failRun();
        end
        checkRgb("chainOut word", rgb_t'(capWord), sent[`LED_NUM_PIXELS]);
        checkLine("chainOut", chainOut, serialLine_t'(2'b00));   // idle again
    endtask

    initial begin
        rst         = 1'b1;
        pixValid    = 1'b0;
        pixIn       = '0;
        credits     = `LED_FIFO_DEPTH;
        returnCount = 0;
        stallCycles = 0;
        rngState    = 32'd39;
        capBits     = 0;
        capWord     = '0;
        for (int k = 0; k < `LED_NUM_PIXELS; k++) shown[k] = '0;
        repeat (4) @(posedge CKI);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(posedge CKI);
        #DRIVE_DELAY;

        testReset();
        pushFrame(`LED_NUM_PIXELS);                    // single frame
        waitDrain();
        checkStrip();
        testLongFrame();
        pushFrame(`LED_NUM_PIXELS);                    // two frames back to back
        pushFrame(`LED_NUM_PIXELS);
        waitDrain();
        checkStrip();
        pushFrame(2);                                  // short frame where the tail keeps old colors
        waitDrain();
        checkStrip();
        testOverlong();

        if (credits == `LED_FIFO_DEPTH) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("credit count ended at %0d", credits);
            failRun();
        end
    end

endmodule

// File: src.f
+incdir+hdl
+incdir+sim
hdl/ledPkg.sv
hdl/pixelFifo.sv
hdl/ws2801Serializer.sv
hdl/ws2801Pixel.sv
hdl/ledStrip.sv
sim/tbLedStrip.sv
